// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = ramio_tb
FILELIST  = ramio.f
BUILD     = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(BUILD)

// ==== io_regs.sv ====
// ------------------------------------------------
// memory-mapped I/O registers
// LED nibble, UART holding registers and the
// go/busy and go/data_ready handshakes
// ------------------------------------------------
`timescale 1ns/1ps

module io_regs (
  input  logic                            clk,
  input  logic                            rst_n,
  input  mem_map_pkg::bus_req_t           req,
  input  logic                            is_io,
  output logic [mem_map_pkg::DATA_W-1:0]  io_rdata,
  output logic [3:0]                      led,
  output logic                            tx_go,
  output logic [7:0]                      tx_byte,
  input  logic                            tx_busy,
  output logic                            rx_go,
  input  logic [7:0]                      rx_byte,
  input  logic                            rx_ready
);
  import mem_map_pkg::*;

  logic [DATA_W-1:0] tx_reg;
  logic [DATA_W-1:0] rx_reg;
  // busy seen since go went up
  logic              tx_started;
  logic              sel_led;
  logic              sel_out;
  logic              sel_in;
  logic              is_wr;
  logic              is_rd;

  // the three I/O words differ only in bits 3:2
  assign sel_led = is_io && (req.addr[3:2] == ADDR_LED[3:2]);
  assign sel_out = is_io && (req.addr[3:2] == ADDR_UART_OUT[3:2]);
  assign sel_in = is_io && (req.addr[3:2] == ADDR_UART_IN[3:2]);
  assign is_wr = req.enable && (req.write_type != SZ_NONE);
  assign is_rd = req.enable && (req.read_type.size != SZ_NONE);

  // LED reads back as zero
  always_comb begin
    io_rdata = '0;
    if (sel_out) begin
      io_rdata = tx_reg;
    end else if (sel_in) begin
      io_rdata = rx_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led <= LED_OFF;
      tx_reg <= IO_IDLE;
      tx_go <= 1'b0;
      tx_started <= 1'b0;
      rx_reg <= IO_IDLE;
      rx_go <= 1'b1;
    end else begin
      // ------------------------------------------------
      // receive side
      // ------------------------------------------------
      // read empties the register
      if (sel_in && is_rd) begin
        rx_reg <= IO_IDLE;
      end
      // new byte wins, an unread one is lost
      if (rx_go && rx_ready) begin
        rx_reg <= {{(DATA_W-8){1'b0}}, rx_byte};
        rx_go <= 1'b0;
      end
      // acknowledge lasts one cycle
      if (!rx_go) begin
        rx_go <= 1'b1;
      end

      // ------------------------------------------------
      // transmit side
      // ------------------------------------------------
      if (tx_go && tx_busy) begin
        tx_started <= 1'b1;
      end
      // frame finished, acknowledge and go idle
      if (tx_go && tx_started && !tx_busy) begin
        tx_go <= 1'b0;
        tx_started <= 1'b0;
        tx_reg <= IO_IDLE;
      end
      if (sel_out && is_wr) begin
        tx_reg <= {{(DATA_W-8){1'b0}}, req.wdata[7:0]};
        tx_go <= 1'b1;
      end

      // LEDs, active low
      if (sel_led && is_wr) begin
        led <= req.wdata[3:0];
      end
    end
  end

  assign tx_byte = tx_reg[7:0];

endmodule

// ==== lane_align.sv ====
// ------------------------------------------------
// lane alignment between client bus and word RAM
// stores become byte-enabled words, loads are
// picked from their lane and extended
// ------------------------------------------------
`timescale 1ns/1ps

module lane_align (
  input  mem_map_pkg::bus_req_t              req,
  input  logic                               is_io,
  input  logic [mem_map_pkg::DATA_W-1:0]     ram_word,
  input  logic                               ram_ready,
  output mem_map_pkg::ram_req_t              ram_req,
  output logic [mem_map_pkg::DATA_W-1:0]     load_data,
  output logic                               load_ready
);
  import mem_map_pkg::*;

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic        ext_bit;

  // ------------------------------------------------
  // store path
  // ------------------------------------------------
  always_comb begin
    // I/O never reaches the RAM
    ram_req.enable = req.enable && !is_io;
    // word index, bits above the RAM depth are dropped
    ram_req.index = req.addr[RAM_WORDS_LOG2+1:2];
    ram_req.be = '0;
    ram_req.wdata = '0;
    if (ram_req.enable) begin
      unique case (req.write_type)
        SZ_BYTE: begin
          // byte copied to every lane, enable picks one
          ram_req.be = BE_W'(1) << req.addr[1:0];
          ram_req.wdata = {4{req.wdata[7:0]}};
        end
        SZ_HALF: begin
          // odd half address writes nothing
          if (!req.addr[0]) begin
            ram_req.be = req.addr[1] ? 4'b1100 : 4'b0011;
          end
          ram_req.wdata = {2{req.wdata[15:0]}};
        end
        SZ_WORD: begin
          ram_req.be = '1;
          ram_req.wdata = req.wdata;
        end
        default: ;
      endcase
    end
  end

  // ------------------------------------------------
  // load path
  // ------------------------------------------------
  always_comb begin
    byte_sel = ram_word[{req.addr[1:0], 3'b000} +: 8];
    half_sel = req.addr[1] ? ram_word[31:16] : ram_word[15:0];
    load_data = '0;
    unique case (req.read_type.size)
      SZ_BYTE: begin
        ext_bit = req.read_type.sign & byte_sel[7];
        load_data = {{(DATA_W-8){ext_bit}}, byte_sel};
      end
      SZ_HALF: begin
        ext_bit = req.read_type.sign & half_sel[15];
        // misaligned half reads as zero
        if (!req.addr[0]) begin
          load_data = {{(DATA_W-16){ext_bit}}, half_sel};
        end
      end
      SZ_WORD: begin
        ext_bit = 1'b0;
        load_data = ram_word;
      end
      default: ext_bit = 1'b0;
    endcase
  end

  // RAM word arrives one cycle after the request
  assign load_ready = ram_ready && ram_req.enable;

endmodule

// ==== mem_map_pkg.sv ====
// ------------------------------------------------
// memory map of the ramio adapter
// access size coding, I/O addresses and the bus,
// response and RAM request structs
// ------------------------------------------------
package mem_map_pkg;

  // client bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W = DATA_W / 8;

  // 256 words of on-chip RAM, upper address bits alias
  localparam int RAM_WORDS_LOG2 = 8;

  // ------------------------------------------------
  // I/O registers at the top of the address space
  // ------------------------------------------------
  // four LEDs in the low nibble, 0 is on
  localparam logic [ADDR_W-1:0] ADDR_LED = 32'hffff_fffc;
  // reads back IO_IDLE when nothing is being sent
  localparam logic [ADDR_W-1:0] ADDR_UART_OUT = ADDR_LED - 4;
  // cleared to IO_IDLE by every read
  localparam logic [ADDR_W-1:0] ADDR_UART_IN = ADDR_UART_OUT - 4;

  localparam logic [DATA_W-1:0] IO_IDLE = '1;
  localparam logic [3:0] LED_OFF = 4'b1111;

  // access size, shared by loads and stores
  typedef enum logic [1:0] {
    SZ_NONE = 2'b00,
    SZ_BYTE = 2'b01,
    SZ_HALF = 2'b10,
    SZ_WORD = 2'b11
  } size_t;

  // load type, sign set means sign extension
  typedef struct packed {
    logic  sign;
    size_t size;
  } read_type_t;

  typedef size_t write_type_t;

  typedef struct packed {
    logic                 enable;
    read_type_t           read_type;
    write_type_t          write_type;
    logic [ADDR_W-1:0]    addr;
    logic [DATA_W-1:0]    wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]    rdata;
    logic                 data_out_ready;
  } bus_rsp_t;

  typedef struct packed {
    logic                      enable;
    logic [RAM_WORDS_LOG2-1:0] index;
    logic [BE_W-1:0]           be;
    logic [DATA_W-1:0]         wdata;
  } ram_req_t;

endpackage

// ==== ramio.f ====
mem_map_pkg.sv
uart_pkg.sv
lane_align.sv
word_ram.sv
uart_tx.sv
uart_rx.sv
io_regs.sv
ramio.sv
ramio_tb.sv

// ==== ramio.sv ====
// ------------------------------------------------
// ramio top level
// decodes each client access to word RAM or I/O
// and returns the load data and ready
// ------------------------------------------------
`timescale 1ns/1ps

module ramio (
  input  logic                    clk,
  input  logic                    rst_n,
  input  mem_map_pkg::bus_req_t   req,
  output mem_map_pkg::bus_rsp_t   rsp,
  output logic [3:0]              led,
  output logic                    uart_tx,
  input  logic                    uart_rx
);
  import mem_map_pkg::*;

  logic              is_io;
  logic              is_load;
  ram_req_t          ram_req;
  logic [DATA_W-1:0] ram_word;
  logic              ram_ready;
  logic [DATA_W-1:0] load_data;
  logic              load_ready;
  logic [DATA_W-1:0] io_rdata;
  logic              tx_go;
  logic [7:0]        tx_byte;
  logic              tx_busy;
  logic              rx_go;
  logic [7:0]        rx_byte;
  logic              rx_ready;

  // single address decode, everything else is RAM
  assign is_io = (req.addr == ADDR_LED) || (req.addr == ADDR_UART_OUT) ||
                 (req.addr == ADDR_UART_IN);
  assign is_load = (req.read_type.size != SZ_NONE);

  // I/O and RAM stores finish at once, RAM loads wait a cycle
  always_comb begin
    rsp.rdata = is_io ? io_rdata : load_data;
    rsp.data_out_ready = req.enable && (is_io || !is_load || load_ready);
  end

  lane_align lane_i (
    .req        (req),
    .is_io      (is_io),
    .ram_word   (ram_word),
    .ram_ready  (ram_ready),
    .ram_req    (ram_req),
    .load_data  (load_data),
    .load_ready (load_ready)
  );

  word_ram ram_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .ram_req (ram_req),
    .is_load (is_load),
    .rdata   (ram_word),
    .ready   (ram_ready)
  );

  io_regs io_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .is_io    (is_io),
    .io_rdata (io_rdata),
    .led      (led),
    .tx_go    (tx_go),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .rx_go    (rx_go),
    .rx_byte  (rx_byte),
    .rx_ready (rx_ready)
  );

  uart_tx tx_i (
    .clk   (clk),
    .rst_n (rst_n),
    .go    (tx_go),
    .data  (tx_byte),
    .busy  (tx_busy),
    .tx    (uart_tx)
  );

  uart_rx rx_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .go         (rx_go),
    .rx         (uart_rx),
    .data       (rx_byte),
    .data_ready (rx_ready)
  );

endmodule

// ==== ramio_tb.sv ====
// ------------------------------------------------
// ramio testbench
// random RAM traffic against a byte model, LED,
// UART transmit and receive through serial models
// ------------------------------------------------
`timescale 1ns/1ps

module ramio_tb;
  import mem_map_pkg::*;
  import uart_pkg::*;

  localparam int NUM_FILL = 1 << RAM_WORDS_LOG2;
  localparam int NUM_RANDOM = 300;
  localparam int NUM_LED = 8;
  localparam int NUM_TX = 8;
  localparam int NUM_RX = 8;
  // fill and random traffic plus serial frames and slack
  localparam int MAX_CYCLES = (NUM_FILL + 2 * NUM_RANDOM + 64) * 4
                              + (NUM_TX + NUM_RX) * 200 + 2000;

  logic       clk;
  logic       rst_n;
  bus_req_t   req;
  bus_rsp_t   rsp;
  logic [3:0] led;
  logic       uart_tx;
  logic       uart_rx;

  // byte-wide reference RAM over the low 10 address bits
  logic [7:0] ram_model [0:1023];
  logic [7:0] tx_frames [$];
  int         errors;
  int         checks;
  int         cycles;

  ramio ramio_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .rsp     (rsp),
    .led     (led),
    .uart_tx (uart_tx),
    .uart_rx (uart_rx)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------
  // checking and reference model
  // ------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] rand_ram_addr();
    logic [31:0] a;
    a = $urandom;
    // the three I/O words are not RAM
    while (a == ADDR_LED || a == ADDR_UART_OUT || a == ADDR_UART_IN) begin
      a = $urandom;
    end
    return a;
  endfunction

  function automatic void model_store(input logic [31:0] addr, input write_type_t wt,
                                      input logic [31:0] d);
    logic [9:0] a;
    logic [9:0] base;
    a = addr[9:0];
    base = {a[9:2], 2'b00};
    case (wt)
      SZ_BYTE: ram_model[a] = d[7:0];
      SZ_HALF: begin
        // odd address writes nothing
        if (!a[0]) begin
          ram_model[a] = d[7:0];
          ram_model[a + 10'd1] = d[15:8];
        end
      end
      SZ_WORD: begin
        for (int i = 0; i < 4; i++) begin
          ram_model[base + 10'(i)] = d[8*i +: 8];
        end
      end
      default: ;
    endcase
  endfunction

  function automatic logic [31:0] model_load(input logic [31:0] addr, input read_type_t rt);
    logic [9:0]  a;
    logic [9:0]  base;
    logic [15:0] h;
    logic        ext;
    a = addr[9:0];
    base = {a[9:2], 2'b00};
    case (rt.size)
      SZ_BYTE: begin
        ext = rt.sign & ram_model[a][7];
        return {{24{ext}}, ram_model[a]};
      end
      SZ_HALF: begin
        if (a[0]) begin
          return 32'd0;
        end
        h = {ram_model[a + 10'd1], ram_model[a]};
        ext = rt.sign & h[15];
        return {{16{ext}}, h};
      end
      SZ_WORD: begin
        return {ram_model[base + 10'd3], ram_model[base + 10'd2],
                ram_model[base + 10'd1], ram_model[base]};
      end
      default: return 32'd0;
    endcase
  endfunction

  // ------------------------------------------------
  // bus access entered and left 1 ns after an edge
  // ------------------------------------------------
  task automatic bus_access(input logic [31:0] addr, input write_type_t wt,
                            input read_type_t rt, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int waited;
    int exp_wait;
    waited = 0;
    // only a RAM load waits for one cycle
    exp_wait = 0;
    if (rt.size != SZ_NONE && addr != ADDR_LED && addr != ADDR_UART_OUT &&
        addr != ADDR_UART_IN) begin
      exp_wait = 1;
    end
    req.enable = 1'b1;
    req.addr = addr;
    req.write_type = wt;
    req.read_type = rt;
    req.wdata = wdata;
    // ready sampled mid-cycle
    @(negedge clk);
    while (!rsp.data_out_ready && waited < 8) begin
      waited++;
      @(negedge clk);
    end
    if (!rsp.data_out_ready) begin
      errors++;
      $display("access to %h at %0t never saw data_out_ready", addr, $time);
    end else begin
      check_value("rsp.data_out_ready wait", 32'(waited), 32'(exp_wait));
    end
    rdata = rsp.rdata;
    @(posedge clk);
    #1;
    req.enable = 1'b0;
    req.write_type = SZ_NONE;
    req.read_type = '{sign: 1'b0, size: SZ_NONE};
  endtask

  task automatic bus_store(input logic [31:0] addr, input write_type_t wt,
                           input logic [31:0] wdata);
    logic [31:0] unused_rdata;
    bus_access(addr, wt, '{sign: 1'b0, size: SZ_NONE}, wdata, unused_rdata);
  endtask

  task automatic bus_load(input logic [31:0] addr, input read_type_t rt,
                          output logic [31:0] rdata);
    bus_access(addr, SZ_NONE, rt, 32'd0, rdata);
  endtask

  // ------------------------------------------------
  // serial models
  // ------------------------------------------------
  // drives one 8N1 frame on uart_rx
  task automatic send_frame(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_tx_frame(input int seen);
    int waited;
    waited = 0;
    while (tx_frames.size() == seen && waited < 12 * CLKS_PER_BIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (tx_frames.size() == seen) begin
      errors++;
      $display("no frame appeared on uart_tx by %0t", $time);
    end
  endtask

  // decoder samples uart_tx mid-bit on falling clock edges
  initial begin : frame_decoder
    logic [7:0] bits;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (uart_tx === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        if (uart_tx !== 1'b0) begin
          errors++;
          $display("start bit on uart_tx too short at %0t", $time);
        end
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          bits[i] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (uart_tx !== 1'b1) begin
          errors++;
          $display("stop bit missing on uart_tx at %0t", $time);
        end
        tx_frames.push_back(bits);
      end
    end
  end

  // run limit
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] got;
    logic [7:0]  b;
    read_type_t  rt;
    int          op;
    int          seen;
    errors = 0;
    checks = 0;
    void'($urandom(32'hfe48));
    req = '0;
    uart_rx = 1'b1;
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // idle state after reset
    check_value("led", {28'd0, led}, {28'd0, LED_OFF});
    check_value("uart_tx", {31'd0, uart_tx}, 32'd1);
    check_value("rsp.data_out_ready", {31'd0, rsp.data_out_ready}, 32'd0);
    bus_load(ADDR_UART_OUT, '{sign: 1'b0, size: SZ_WORD}, got);
    check_value("uart_out_reg", got, IO_IDLE);
    bus_load(ADDR_UART_IN, '{sign: 1'b0, size: SZ_WORD}, got);
    check_value("uart_in_reg", got, IO_IDLE);

    // fill every word with random upper bits that alias
    for (int i = 0; i < NUM_FILL; i++) begin
      data = rand_ram_addr();
      addr = {data[31:RAM_WORDS_LOG2 + 2], 8'(i), 2'b00};
      if (addr == ADDR_LED || addr == ADDR_UART_OUT || addr == ADDR_UART_IN) begin
        addr = {22'd0, 8'(i), 2'b00};
      end
      data = $urandom;
      bus_store(addr, SZ_WORD, data);
      model_store(addr, SZ_WORD, data);
    end

    // mixed random RAM traffic
    for (int i = 0; i < NUM_RANDOM; i++) begin
      op = $urandom_range(5, 0);
      addr = rand_ram_addr();
      data = $urandom;
      rt.sign = 1'($urandom_range(1, 0));
      case (op)
        0: begin
          // word store then read back
          bus_store(addr, SZ_WORD, data);
          model_store(addr, SZ_WORD, data);
          rt.size = SZ_WORD;
        end
        1: rt.size = SZ_WORD;
        2: begin
          bus_store(addr, SZ_BYTE, data);
          model_store(addr, SZ_BYTE, data);
          rt.size = SZ_BYTE;
        end
        3: rt.size = SZ_BYTE;
        4: begin
          bus_store(addr, SZ_HALF, data);
          model_store(addr, SZ_HALF, data);
          rt.size = SZ_HALF;
        end
        default: rt.size = SZ_HALF;
      endcase
      bus_load(addr, rt, got);
      check_value("rsp.rdata", got, model_load(addr, rt));
      // whole word shows which lanes a half store touched
      if (op == 4) begin
        rt = '{sign: 1'b0, size: SZ_WORD};
        bus_load(addr, rt, got);
        check_value("rsp.rdata", got, model_load(addr, rt));
      end
    end

    // LED stores of an active low nibble
    for (int i = 0; i < NUM_LED; i++) begin
      data = $urandom;
      bus_store(ADDR_LED, SZ_WORD, data);
      check_value("led", {28'd0, led}, {28'd0, data[3:0]});
    end
    bus_load(ADDR_LED, '{sign: 1'b0, size: SZ_WORD}, got);
    check_value("led_reg", got, 32'd0);

    // transmit frames
    for (int i = 0; i < NUM_TX; i++) begin
      data = $urandom;
      b = data[7:0];
      seen = tx_frames.size();
      bus_store(ADDR_UART_OUT, SZ_WORD, data);
      bus_load(ADDR_UART_OUT, '{sign: 1'b0, size: SZ_WORD}, got);
      check_value("uart_out_reg", got, {24'd0, b});
      // still sending mid-frame
      repeat (4 * CLKS_PER_BIT) @(posedge clk);
      #1;
      bus_load(ADDR_UART_OUT, '{sign: 1'b0, size: SZ_WORD}, got);
      check_value("uart_out_reg", got, {24'd0, b});
      wait_tx_frame(seen);
      if (tx_frames.size() > seen) begin
        check_value("uart_tx_frame", {24'd0, tx_frames[seen]}, {24'd0, b});
      end
      // rest of the stop bit plus the go/busy release
      repeat (CLKS_PER_BIT) @(posedge clk);
      #1;
      bus_load(ADDR_UART_OUT, '{sign: 1'b0, size: SZ_WORD}, got);
      check_value("uart_out_reg", got, IO_IDLE);
    end

    // receive frames
    for (int i = 0; i < NUM_RX; i++) begin
      b = 8'($urandom);
      send_frame(b);
      bus_load(ADDR_UART_IN, '{sign: 1'b0, size: SZ_WORD}, got);
      check_value("uart_in_reg", got, {24'd0, b});
      bus_load(ADDR_UART_IN, '{sign: 1'b0, size: SZ_WORD}, got);
      check_value("uart_in_reg", got, IO_IDLE);
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== uart_pkg.sv ====
// ------------------------------------------------
// serial line timing for the UART engines
// ------------------------------------------------
package uart_pkg;

  // system clock
  localparam int CLOCK_HZ = 1_600_000;

  // line rate, 8N1 frames
  localparam int BAUD_RATE = 100_000;

  // one serial bit in clock cycles
  localparam int CLKS_PER_BIT = CLOCK_HZ / BAUD_RATE;

  // width of the bit period counter
  localparam int CNT_W = $clog2(CLKS_PER_BIT);

  // frame is start, eight data, stop
  localparam int DATA_BITS = 8;

endpackage

// ==== uart_rx.sv ====
// ------------------------------------------------
// 8N1 serial receiver
// samples mid-bit, holds data_ready until go falls
// ------------------------------------------------
`timescale 1ns/1ps

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go,
  input  logic       rx,
  output logic [7:0] data,
  output logic       data_ready
);
  import uart_pkg::*;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_READY
  } rx_state_t;

  rx_state_t        state;
  logic [1:0]       rx_sync;
  logic             rx_s;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;

  // two-flop synchronizer, idles high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;
    end else begin
      rx_sync <= {rx_sync[0], rx};
    end
  end
  assign rx_s = rx_sync[1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= RX_IDLE;
      cnt <= '0;
      bit_idx <= '0;
    end else begin
      cnt <= cnt + CNT_W'(1);
      unique case (state)
        RX_IDLE: begin
          // hunt for a falling edge only while go
          cnt <= '0;
          if (go && !rx_s) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // middle of the start bit, glitch check
          if (cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
            cnt <= '0;
            bit_idx <= '0;
            state <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            cnt <= '0;
            // lsb first
            data <= {rx_s, data[7:1]};
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'(DATA_BITS - 1)) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          // framing error drops the byte
          if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            state <= rx_s ? RX_READY : RX_IDLE;
          end
        end
        RX_READY: begin
          if (!go) begin
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  assign data_ready = (state == RX_READY);

endmodule

// ==== uart_tx.sv ====
// ------------------------------------------------
// 8N1 serial transmitter
// go starts a frame, busy high while sending,
// next frame waits for go to fall
// ------------------------------------------------
`timescale 1ns/1ps

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       go,
  input  logic [7:0] data,
  output logic       busy,
  output logic       tx
);
  import uart_pkg::*;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_SEND,
    TX_DONE
  } tx_state_t;

  tx_state_t          state;
  logic [CNT_W-1:0]   cnt;
  logic [3:0]         bit_idx;
  // stop, data lsb first, start
  logic [DATA_BITS+1:0] shreg;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= TX_IDLE;
      cnt <= '0;
      bit_idx <= '0;
      shreg <= '1;
    end else begin
      unique case (state)
        TX_IDLE: begin
          if (go) begin
            shreg <= {1'b1, data, 1'b0};
            cnt <= '0;
            bit_idx <= '0;
            state <= TX_SEND;
          end
        end
        TX_SEND: begin
          if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            cnt <= '0;
            if (bit_idx == 4'(DATA_BITS + 1)) begin
              // stop bit done
              state <= TX_DONE;
            end else begin
              // line idles high behind the frame
              shreg <= {1'b1, shreg[DATA_BITS+1:1]};
              bit_idx <= bit_idx + 4'd1;
            end
          end else begin
            cnt <= cnt + CNT_W'(1);
          end
        end
        TX_DONE: begin
          // wait for the acknowledge
          if (!go) begin
            state <= TX_IDLE;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  assign busy = (state == TX_SEND);
  assign tx = shreg[0];

endmodule

// ==== word_ram.sv ====
// ------------------------------------------------
// synchronous word RAM with byte enables
// read word and ready one cycle after a load
// ------------------------------------------------
`timescale 1ns/1ps

module word_ram (
  input  logic                            clk,
  input  logic                            rst_n,
  input  mem_map_pkg::ram_req_t           ram_req,
  input  logic                            is_load,
  output logic [mem_map_pkg::DATA_W-1:0]  rdata,
  output logic                            ready
);
  import mem_map_pkg::*;

  logic [DATA_W-1:0] mem [2**RAM_WORDS_LOG2];

  // write enabled bytes, read the old word
  always_ff @(posedge clk) begin
    if (ram_req.enable) begin
      for (int b = 0; b < BE_W; b++) begin
        if (ram_req.be[b]) begin
          mem[ram_req.index][8*b +: 8] <= ram_req.wdata[8*b +: 8];
        end
      end
      rdata <= mem[ram_req.index];
    end
  end

  // one ready cycle per held load, then one idle cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= ram_req.enable && is_load && !ready;
    end
  end

endmodule
